// ==== common/stats_pkg.sv ====
package stats_pkg;

  localparam int DATA_WIDTH = 16;
  localparam int STAT_WIDTH = 32;

  localparam int BUF_DEPTH = 4;

  // Pointers index the buffer entries; the fill level must also hold BUF_DEPTH itself.
  localparam int PTR_WIDTH = $clog2(BUF_DEPTH);
  localparam int OCC_WIDTH = $clog2(BUF_DEPTH + 1);

  typedef logic [DATA_WIDTH-1:0] data_t;
  typedef logic [STAT_WIDTH-1:0] stat_t;
  typedef logic [PTR_WIDTH-1:0]  ptr_t;
  typedef logic [OCC_WIDTH-1:0]  occ_t;

  // Statistic selectors shared by the command port and the clear decoder.
  typedef enum logic [2:0] {
    STAT_WORDS_IN  = 3'd0,  // Words accepted at the input.
    STAT_WORDS_OUT = 3'd1,  // Words delivered at the output.
    STAT_OCCUPANCY = 3'd2,  // Current fill level, not clearable.
    STAT_BLOCKED   = 3'd3,  // Cycles with a word offered to a full buffer.
    STAT_PEAK_OCC  = 3'd4   // Highest fill level seen since the last clear.
  } stat_id_e;

  typedef enum logic {
    OP_READ       = 1'b0,
    OP_READ_CLEAR = 1'b1  // Read, then zero the counter on the next cycle.
  } op_e;

endpackage

// ==== stats/stats_cnt.sv ====
module stats_cnt
  import stats_pkg::*;
(
  input  logic  clk,
  input  logic  rst_n,
  input  logic  clr,
  input  logic  inc,
  input  logic  dec,
  output stat_t cnt
);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      cnt <= '0;
    end else if (clr) begin
      cnt <= '0;                    // Clear beats any count event.
    end else if (inc && !dec) begin
      cnt <= cnt + 1'b1;
    end else if (dec && !inc) begin
      cnt <= cnt - 1'b1;
    end
  end

  // A lone decrement at zero would wrap to the top, which no statistic should ever see.
  a_no_underflow: assert property (
    @(posedge clk) disable iff (!rst_n)
    (dec && !inc) |-> (cnt != '0)
  ) else $error("stats_cnt: decrement at zero");

endmodule

// ==== stats/stats_bank.sv ====
module stats_bank
  import stats_pkg::*;
(
  input  logic     clk,
  input  logic     rst_n,
  input  logic     push,
  input  logic     pop,
  input  logic     blocked,
  input  occ_t     occupancy,
  input  logic     clr_req,
  input  stat_id_e clr_id,
  output stat_t    words_in,
  output stat_t    words_out,
  output stat_t    occ_stat,
  output stat_t    blocked_cycles,
  output stat_t    peak_occ
);

  logic clr_words_in;
  logic clr_words_out;
  logic clr_blocked;
  logic clr_peak;
  occ_t peak_q;

  // A clear aimed at STAT_OCCUPANCY decodes to nothing.
  assign clr_words_in  = clr_req && (clr_id == STAT_WORDS_IN);
  assign clr_words_out = clr_req && (clr_id == STAT_WORDS_OUT);
  assign clr_blocked   = clr_req && (clr_id == STAT_BLOCKED);
  assign clr_peak      = clr_req && (clr_id == STAT_PEAK_OCC);

  stats_cnt u_words_in (
    .clk  (clk),
    .rst_n(rst_n),
    .clr  (clr_words_in),
    .inc  (push),
    .dec  (1'b0),
    .cnt  (words_in)
  );

  stats_cnt u_words_out (
    .clk  (clk),
    .rst_n(rst_n),
    .clr  (clr_words_out),
    .inc  (pop),
    .dec  (1'b0),
    .cnt  (words_out)
  );

  // Tracks the fill level from the same events the buffer uses.
  stats_cnt u_occupancy (
    .clk  (clk),
    .rst_n(rst_n),
    .clr  (1'b0),
    .inc  (push),
    .dec  (pop),
    .cnt  (occ_stat)
  );

  stats_cnt u_blocked (
    .clk  (clk),
    .rst_n(rst_n),
    .clr  (clr_blocked),
    .inc  (blocked),
    .dec  (1'b0),
    .cnt  (blocked_cycles)
  );

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      peak_q <= '0;
    end else if (clr_peak) begin
      peak_q <= '0;
    end else if (occupancy > peak_q) begin
      peak_q <= occupancy;
    end
  end

  assign peak_occ = stat_t'(peak_q);

  // The counter copy of the fill level must agree with the buffer's own count.
  a_occ_match: assert property (
    @(posedge clk) disable iff (!rst_n)
    1'b1 |=> (occ_stat == stat_t'(occupancy))
  ) else $error("stats_bank: occupancy statistic differs from buffer fill level");

endmodule

// ==== src/stream_buffer.sv ====
module stream_buffer
  import stats_pkg::*;
(
  input  logic  clk,
  input  logic  rst_n,
  input  logic  in_valid,
  input  data_t in_data,
  output logic  in_ready,
  output logic  out_valid,
  output data_t out_data,
  input  logic  out_ready,
  output logic  push,
  output logic  pop,
  output logic  blocked,
  output occ_t  occupancy
);

  data_t mem [BUF_DEPTH];
  ptr_t  wr_ptr;
  ptr_t  rd_ptr;
  occ_t  count;

  function automatic ptr_t ptr_next(input ptr_t ptr);
    if (ptr == ptr_t'(BUF_DEPTH - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  // Both ready and valid come from the registered count only.
  assign in_ready  = (count != occ_t'(BUF_DEPTH));
  assign out_valid = (count != '0);
  assign out_data  = mem[rd_ptr];

  assign push    = in_valid && in_ready;
  assign pop     = out_valid && out_ready;
  assign blocked = in_valid && !in_ready;

  assign occupancy = count;

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= in_data;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= ptr_next(wr_ptr);
      end
      if (pop) begin
        rd_ptr <= ptr_next(rd_ptr);
      end
      if (push && !pop) begin
        count <= count + 1'b1;
      end else if (pop && !push) begin
        count <= count - 1'b1;
      end
    end
  end

  a_count_bound: assert property (
    @(posedge clk) disable iff (!rst_n)
    count <= occ_t'(BUF_DEPTH)
  ) else $error("stream_buffer: fill count above depth");

  // Head word must not move while the sink stalls.
  a_out_stable: assert property (
    @(posedge clk) disable iff (!rst_n)
    (out_valid && !out_ready) |=> (out_valid && $stable(out_data))
  ) else $error("stream_buffer: output word changed under back-pressure");

endmodule

// ==== src/stats_readout.sv ====
module stats_readout
  import stats_pkg::*;
(
  input  logic     clk,
  input  logic     rst_n,
  input  logic     cmd_valid,
  output logic     cmd_ready,
  input  op_e      cmd_op,
  input  stat_id_e cmd_id,
  output logic     rsp_valid,
  input  logic     rsp_ready,
  output stat_t    rsp_value,
  input  stat_t    words_in,
  input  stat_t    words_out,
  input  stat_t    occ_stat,
  input  stat_t    blocked_cycles,
  input  stat_t    peak_occ,
  output logic     clr_req,
  output stat_id_e clr_id
);

  typedef enum logic {
    IDLE    = 1'b0,
    RESPOND = 1'b1
  } state_e;

  state_e state;
  stat_t  sel_value;
  logic   cmd_fire;

  assign cmd_ready = (state == IDLE);
  assign rsp_valid = (state == RESPOND);
  assign cmd_fire  = cmd_valid && cmd_ready;

  always_comb begin
    case (cmd_id)
      STAT_WORDS_IN:  sel_value = words_in;
      STAT_WORDS_OUT: sel_value = words_out;
      STAT_OCCUPANCY: sel_value = occ_stat;
      STAT_BLOCKED:   sel_value = blocked_cycles;
      STAT_PEAK_OCC:  sel_value = peak_occ;
      default:        sel_value = '0;  // Unused ids read as zero.
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state   <= IDLE;
      clr_req <= 1'b0;
    end else begin
      clr_req <= cmd_fire && (cmd_op == OP_READ_CLEAR);  // One-cycle pulse.
      case (state)
        IDLE:    if (cmd_fire) state <= RESPOND;
        RESPOND: if (rsp_ready) state <= IDLE;
        default: state <= IDLE;
      endcase
    end
  end

  // Value is captured before the clear lands, so a read-clear returns the old count.
  always_ff @(posedge clk) begin
    if (cmd_fire) begin
      rsp_value <= sel_value;
      clr_id    <= cmd_id;
    end
  end

  a_rsp_hold: assert property (
    @(posedge clk) disable iff (!rst_n)
    (rsp_valid && !rsp_ready) |=> (rsp_valid && $stable(rsp_value))
  ) else $error("stats_readout: response changed before it was taken");

endmodule

// ==== src/stream_stats_top.sv ====
module stream_stats_top
  import stats_pkg::*;
(
  input  logic     clk,
  input  logic     rst_n,
  input  logic     in_valid,
  input  data_t    in_data,
  output logic     in_ready,
  output logic     out_valid,
  output data_t    out_data,
  input  logic     out_ready,
  input  logic     cmd_valid,
  output logic     cmd_ready,
  input  op_e      cmd_op,
  input  stat_id_e cmd_id,
  output logic     rsp_valid,
  input  logic     rsp_ready,
  output stat_t    rsp_value
);

  logic     push;
  logic     pop;
  logic     blocked;
  occ_t     occupancy;
  logic     clr_req;
  stat_id_e clr_id;
  stat_t    words_in;
  stat_t    words_out;
  stat_t    occ_stat;
  stat_t    blocked_cycles;
  stat_t    peak_occ;

  stream_buffer u_buffer (
    .clk      (clk),
    .rst_n    (rst_n),
    .in_valid (in_valid),
    .in_data  (in_data),
    .in_ready (in_ready),
    .out_valid(out_valid),
    .out_data (out_data),
    .out_ready(out_ready),
    .push     (push),
    .pop      (pop),
    .blocked  (blocked),
    .occupancy(occupancy)
  );

  stats_bank u_bank (
    .clk           (clk),
    .rst_n         (rst_n),
    .push          (push),
    .pop           (pop),
    .blocked       (blocked),
    .occupancy     (occupancy),
    .clr_req       (clr_req),
    .clr_id        (clr_id),
    .words_in      (words_in),
    .words_out     (words_out),
    .occ_stat      (occ_stat),
    .blocked_cycles(blocked_cycles),
    .peak_occ      (peak_occ)
  );

  stats_readout u_readout (
    .clk           (clk),
    .rst_n         (rst_n),
    .cmd_valid     (cmd_valid),
    .cmd_ready     (cmd_ready),
    .cmd_op        (cmd_op),
    .cmd_id        (cmd_id),
    .rsp_valid     (rsp_valid),
    .rsp_ready     (rsp_ready),
    .rsp_value     (rsp_value),
    .words_in      (words_in),
    .words_out     (words_out),
    .occ_stat      (occ_stat),
    .blocked_cycles(blocked_cycles),
    .peak_occ      (peak_occ),
    .clr_req       (clr_req),
    .clr_id        (clr_id)
  );

endmodule

// ==== dv/stream_stats_tb.sv ====
module stream_stats_tb
  import stats_pkg::*;
();

  localparam int CLK_PERIOD      = 4;
  localparam int RESET_CYCLES    = 10;
  localparam int N_RANDOM_WORDS  = 200;
  localparam int N_EXTRA_OFFERS  = 6;
  localparam int N_WORDS         = N_RANDOM_WORDS + BUF_DEPTH + N_EXTRA_OFFERS;
  localparam int N_CMDS          = 30;
  localparam int WATCHDOG_CYCLES = 40 * N_WORDS + 20 * N_CMDS + RESET_CYCLES;

  logic     clk;
  logic     rst_n;
  logic     in_valid;
  data_t    in_data;
  logic     in_ready;
  logic     out_valid;
  data_t    out_data;
  logic     out_ready;
  logic     cmd_valid;
  logic     cmd_ready;
  op_e      cmd_op;
  stat_id_e cmd_id;
  logic     rsp_valid;
  logic     rsp_ready;
  stat_t    rsp_value;

  integer   seed = 65;

  // Reference model state, updated once per cycle from the observed handshakes.
  stat_t    m_words_in;
  stat_t    m_words_out;
  stat_t    m_occ;
  stat_t    m_blocked;
  stat_t    m_peak;
  logic     clr_pending;
  stat_id_e clr_pending_id;
  data_t    exp_words[$];
  stat_t    exp_rsp[$];
  data_t    exp_word;
  stat_t    exp_value;
  logic     push_ev;
  logic     pop_ev;
  logic     blk_ev;
  logic     cmd_ev;
  logic     rsp_ev;

  stat_id_e all_ids[5] = '{STAT_WORDS_IN, STAT_WORDS_OUT, STAT_OCCUPANCY, STAT_BLOCKED,
                           STAT_PEAK_OCC};

  stream_stats_top UUT (
    .clk      (clk),
    .rst_n    (rst_n),
    .in_valid (in_valid),
    .in_data  (in_data),
    .in_ready (in_ready),
    .out_valid(out_valid),
    .out_data (out_data),
    .out_ready(out_ready),
    .cmd_valid(cmd_valid),
    .cmd_ready(cmd_ready),
    .cmd_op   (cmd_op),
    .cmd_id   (cmd_id),
    .rsp_valid(rsp_valid),
    .rsp_ready(rsp_ready),
    .rsp_value(rsp_value)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  task automatic abort_run(input string reason);
    $display("%0t: %s", $time, reason);
    $display("Done: errors found");
    $fatal(1, "Simulation stopped after a failure.");
  endtask

  task automatic check_word(input string name, input data_t exp, input data_t act);
    if (act !== exp) begin
      $display("CHECK FAILED at %0t: %s expected %h, actual %h", $time, name, exp, act);
      abort_run("Stream word mismatch.");
    end
  endtask

  task automatic check_stat(input string name, input stat_t exp, input stat_t act);
    if (act !== exp) begin
      $display("CHECK FAILED at %0t: %s expected %0d, actual %0d", $time, name, exp, act);
      abort_run("Statistic mismatch.");
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("CHECK FAILED at %0t: %s expected %b, actual %b", $time, name, exp, act);
      abort_run("Handshake flag mismatch.");
    end
  endtask

  // Counter rule: clear wins, inc and dec together hold, otherwise count by one.
  function automatic stat_t next_count(input stat_t cur, input logic inc, input logic dec,
                                       input logic clr);
    if (clr) begin
      return '0;
    end
    if (inc && !dec) begin
      return cur + 1;
    end
    if (dec && !inc) begin
      return cur - 1;
    end
    return cur;
  endfunction

  function automatic stat_t next_peak(input stat_t peak, input stat_t occ, input logic clr);
    if (clr) begin
      return '0;
    end
    return (occ > peak) ? occ : peak;
  endfunction

  function automatic stat_t model_stat(input stat_id_e id);
    case (id)
      STAT_WORDS_IN:  return m_words_in;
      STAT_WORDS_OUT: return m_words_out;
      STAT_OCCUPANCY: return m_occ;
      STAT_BLOCKED:   return m_blocked;
      default:        return m_peak;
    endcase
  endfunction

  // Sampled at the falling edge, where every port is settled.
  always @(negedge clk) begin
    if (!rst_n) begin
      m_words_in  = '0;
      m_words_out = '0;
      m_occ       = '0;
      m_blocked   = '0;
      m_peak      = '0;
      clr_pending = 1'b0;
      exp_words.delete();
      exp_rsp.delete();
    end else begin
      push_ev = in_valid && in_ready;
      pop_ev  = out_valid && out_ready;
      blk_ev  = in_valid && !in_ready;
      cmd_ev  = cmd_valid && cmd_ready;
      rsp_ev  = rsp_valid && rsp_ready;
      if (pop_ev) begin
        if (exp_words.size() == 0) begin
          abort_run("Output delivered a word that was never accepted.");
        end else begin
          exp_word = exp_words.pop_front();
          check_word("out_data", exp_word, out_data);
        end
      end
      if (push_ev) begin
        exp_words.push_back(in_data);
      end
      if (rsp_ev) begin
        if (exp_rsp.size() == 0) begin
          abort_run("Response appeared without an accepted command.");
        end else begin
          exp_value = exp_rsp.pop_front();
          check_stat("rsp_value", exp_value, rsp_value);
        end
      end
      if (cmd_ev) begin
        exp_rsp.push_back(model_stat(cmd_id));
      end
      m_peak      = next_peak(m_peak, m_occ, clr_pending && clr_pending_id == STAT_PEAK_OCC);
      m_words_in  = next_count(m_words_in, push_ev, 1'b0,
                               clr_pending && clr_pending_id == STAT_WORDS_IN);
      m_words_out = next_count(m_words_out, pop_ev, 1'b0,
                               clr_pending && clr_pending_id == STAT_WORDS_OUT);
      m_occ       = next_count(m_occ, push_ev, pop_ev, 1'b0);  // Occupancy is never cleared.
      m_blocked   = next_count(m_blocked, blk_ev, 1'b0,
                               clr_pending && clr_pending_id == STAT_BLOCKED);
      clr_pending    = cmd_ev && (cmd_op == OP_READ_CLEAR);
      clr_pending_id = cmd_id;
    end
  end

  // Every task below starts and ends one time unit after a rising edge.
  task automatic do_cmd(input op_e op, input stat_id_e id, output stat_t value);
    int waited;
    waited    = 0;
    cmd_valid = 1'b1;
    cmd_op    = op;
    cmd_id    = id;
    rsp_ready = 1'b1;
    @(negedge clk);
    while (!cmd_ready) begin
      waited++;
      if (waited > 20) begin
        abort_run("Command port never became ready.");
      end
      @(negedge clk);
    end
    @(posedge clk);
    #1;
    cmd_valid = 1'b0;
    @(negedge clk);
    while (!rsp_valid) begin
      waited++;
      if (waited > 20) begin
        abort_run("Response never arrived.");
      end
      @(negedge clk);
    end
    value = rsp_value;
    @(posedge clk);
    #1;
  endtask

  task automatic drain_output();
    int waited;
    waited    = 0;
    out_ready = 1'b1;
    @(negedge clk);
    while (out_valid) begin
      waited++;
      if (waited > BUF_DEPTH + 2) begin
        abort_run("Buffer did not drain with the sink ready.");
      end
      @(negedge clk);
    end
    @(posedge clk);
    #1;
  endtask

  task automatic check_after_reset();
    stat_t value;
    @(negedge clk);
    check_flag("out_valid", 1'b0, out_valid);
    check_flag("in_ready", 1'b1, in_ready);
    check_flag("cmd_ready", 1'b1, cmd_ready);
    @(posedge clk);
    #1;
    foreach (all_ids[i]) begin
      do_cmd(OP_READ, all_ids[i], value);
      check_stat(all_ids[i].name(), '0, value);
    end
  endtask

  task automatic run_random_traffic(input int n);
    int   sent;
    logic fire;
    sent = 0;
    while (sent < n) begin
      if (!in_valid && (($random(seed) & 3) != 0)) begin
        in_valid = 1'b1;
        in_data  = data_t'($random(seed));
      end
      out_ready = (($random(seed) % 10) < 7);
      @(negedge clk);
      fire = in_valid && in_ready;
      @(posedge clk);
      #1;
      if (fire) begin
        in_valid = 1'b0;
        sent++;
      end
    end
    drain_output();
  endtask

  task automatic check_idle_counts(input int n);
    stat_t value;
    do_cmd(OP_READ, STAT_WORDS_IN, value);
    check_stat("words_in", stat_t'(n), value);
    do_cmd(OP_READ, STAT_WORDS_OUT, value);
    check_stat("words_out", stat_t'(n), value);
    do_cmd(OP_READ, STAT_OCCUPANCY, value);
    check_stat("occupancy", '0, value);
    do_cmd(OP_READ, STAT_PEAK_OCC, value);
    do_cmd(OP_READ, STAT_BLOCKED, value);
  endtask

  task automatic check_read_clear(input int n);
    stat_t value;
    do_cmd(OP_READ_CLEAR, STAT_WORDS_IN, value);
    check_stat("words_in before clear", stat_t'(n), value);
    do_cmd(OP_READ, STAT_WORDS_IN, value);
    check_stat("words_in after clear", '0, value);
    do_cmd(OP_READ_CLEAR, STAT_WORDS_OUT, value);
    check_stat("words_out before clear", stat_t'(n), value);
    do_cmd(OP_READ, STAT_WORDS_OUT, value);
    check_stat("words_out after clear", '0, value);
  endtask

  task automatic check_fill_and_block();
    stat_t value;
    int    accepted;
    logic  fire;
    accepted = 0;
    do_cmd(OP_READ_CLEAR, STAT_BLOCKED, value);
    do_cmd(OP_READ_CLEAR, STAT_PEAK_OCC, value);
    out_ready = 1'b0;
    in_valid  = 1'b1;
    in_data   = data_t'($random(seed));
    repeat (BUF_DEPTH + N_EXTRA_OFFERS) begin
      @(negedge clk);
      fire = in_ready;
      if (fire) begin
        accepted++;
      end
      @(posedge clk);
      #1;
      if (fire) begin
        in_data = data_t'($random(seed));
      end
    end
    in_valid = 1'b0;
    check_stat("accepted words", stat_t'(BUF_DEPTH), stat_t'(accepted));
    @(negedge clk);
    check_flag("in_ready", 1'b0, in_ready);
    @(posedge clk);
    #1;
    do_cmd(OP_READ, STAT_BLOCKED, value);
    check_stat("blocked_cycles", stat_t'(N_EXTRA_OFFERS), value);
    do_cmd(OP_READ_CLEAR, STAT_OCCUPANCY, value);
    check_stat("occupancy before clear", stat_t'(BUF_DEPTH), value);
    do_cmd(OP_READ, STAT_OCCUPANCY, value);
    check_stat("occupancy after clear", stat_t'(BUF_DEPTH), value);
    do_cmd(OP_READ, STAT_PEAK_OCC, value);
    check_stat("peak_occ", stat_t'(BUF_DEPTH), value);
    drain_output();
  endtask

  task automatic check_held_response();
    stat_t held;
    cmd_valid = 1'b1;
    cmd_op    = OP_READ;
    cmd_id    = STAT_WORDS_IN;
    rsp_ready = 1'b0;
    @(negedge clk);
    check_flag("cmd_ready", 1'b1, cmd_ready);
    @(posedge clk);
    #1;
    cmd_id = STAT_BLOCKED;  // A second command waits while the response is pending.
    @(negedge clk);
    check_flag("rsp_valid", 1'b1, rsp_valid);
    held = rsp_value;
    check_stat("held words_in", stat_t'(BUF_DEPTH), held);
    repeat (5) begin
      @(negedge clk);
      check_flag("rsp_valid", 1'b1, rsp_valid);
      check_flag("cmd_ready", 1'b0, cmd_ready);
      check_stat("rsp_value", held, rsp_value);
    end
    @(posedge clk);
    #1;
    cmd_valid = 1'b0;
    rsp_ready = 1'b1;
    @(posedge clk);
    #1;
  endtask

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    abort_run("Watchdog expired: the run hung.");
  end

  initial begin
    clk       = 1'b0;
    rst_n     = 1'b0;
    in_valid  = 1'b0;
    in_data   = '0;
    out_ready = 1'b0;
    cmd_valid = 1'b0;
    cmd_op    = OP_READ;
    cmd_id    = STAT_WORDS_IN;
    rsp_ready = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    rst_n = 1'b1;
    check_after_reset();
    run_random_traffic(N_RANDOM_WORDS);
    check_idle_counts(N_RANDOM_WORDS);
    check_read_clear(N_RANDOM_WORDS);
    check_fill_and_block();
    check_held_response();
    @(negedge clk);
    if (exp_words.size() != 0 || exp_rsp.size() != 0) begin
      abort_run("Words or responses were still outstanding at the end.");
    end else begin
      $display("Done: no errors");
      $finish;
    end
  end

endmodule

// ==== verilog.f ====
common/stats_pkg.sv
stats/stats_cnt.sv
stats/stats_bank.sv
src/stream_buffer.sv
src/stats_readout.sv
src/stream_stats_top.sv
dv/stream_stats_tb.sv
